// File: logic/imul_pkg.sv
/*
  Shared types for the variable-latency multiplier.
  Unsigned operands only; the response carries the low half of the product.
*/

`default_nettype none

package imul_pkg;

  //--------------------------------------------------------------------
  // Widths
  //--------------------------------------------------------------------

  // Operand and product width
  localparam int imul_width = 32;

  // Skip count covers 0 to 8 zero bits
  localparam int imul_shamt_width = 4;

  //--------------------------------------------------------------------
  // Messages
  //--------------------------------------------------------------------

  // One operand pair
  typedef struct packed {
    logic [imul_width-1:0] a;
    logic [imul_width-1:0] b;
  } imul_req_t;

  // Low 32 bits of a * b
  typedef struct packed {
    logic [imul_width-1:0] product;
  } imul_resp_t;

  //--------------------------------------------------------------------
  // Control FSM states
  //--------------------------------------------------------------------

  typedef enum logic [1:0] {
    state_idle,
    state_calc,
    state_done
  } imul_state_e;

endpackage

`default_nettype wire

// File: logic/imul_req_queue.sv
/*
  One-entry request buffer. Ready is low while full unless the entry
  leaves on the same edge. Message is stable while deq_val is high.
*/

`timescale 1ns/10ps
`default_nettype none

module imul_req_queue (
  input  wire                  clk,
  input  wire                  reset,

  // Upstream side
  input  wire                  enq_val,
  output logic                 enq_rdy,
  input  imul_pkg::imul_req_t  enq_msg,

  // Downstream side
  output logic                 deq_val,
  input  wire                  deq_rdy,
  output imul_pkg::imul_req_t  deq_msg
);

  import imul_pkg::*;

  logic      full;
  logic      enq_go;
  logic      deq_go;
  imul_req_t msg_reg;

  // Transfers
  assign enq_go = enq_val & enq_rdy;
  assign deq_go = deq_val & deq_rdy;

  // Accept when empty or when the held entry leaves this cycle
  assign enq_rdy = ~full | deq_rdy;

  // Full flag
  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (enq_go) begin
      full <= 1'b1;
    end else if (deq_go) begin
      full <= 1'b0;
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (enq_go) begin
      msg_reg <= enq_msg;
    end
  end

  assign deq_val = full;
  assign deq_msg = msg_reg;

endmodule

`default_nettype wire

// File: logic/imul_dpath.sv
/*
  Shift-and-add datapath. Each calc step skips up to 8 trailing zeros
  of b. Only the low imul_width bits of the product are kept.
*/

`timescale 1ns/10ps
`default_nettype none

module imul_dpath (
  input  wire                  clk,
  input  wire                  reset,

  // Operands in, product out
  input  imul_pkg::imul_req_t  req,
  output imul_pkg::imul_resp_t product,

  // From control
  input  wire                  a_sel,
  input  wire                  b_sel,
  input  wire                  add_sel,
  input  wire                  result_clear,
  input  wire                  result_en,

  // To control
  output logic                 b_more,
  output logic                 b_lsb
);

  import imul_pkg::*;

  logic [imul_width-1:0]       a_reg;
  logic [imul_width-1:0]       b_reg;
  logic [imul_width-1:0]       result_reg;
  logic [imul_shamt_width-1:0] skip;
  logic [imul_width-1:0]       a_skip;
  logic [imul_width-1:0]       b_skip;
  logic [imul_width-1:0]       a_next;
  logic [imul_width-1:0]       b_next;
  logic [imul_width-1:0]       sum;
  logic [imul_width-1:0]       result_next;

  //--------------------------------------------------------------------
  // Operand registers
  //--------------------------------------------------------------------

  // Select 1 loads the request, 0 takes the shifted value
  always_ff @(posedge clk) begin
    a_reg <= a_sel ? req.a : a_next;
    b_reg <= b_sel ? req.b : b_next;
  end

  //--------------------------------------------------------------------
  // Trailing-zero counter on b[7:0]
  //--------------------------------------------------------------------

  // All eight low bits zero gives the full skip of 8
  always_comb begin
    skip = imul_shamt_width'(8);
    for (int i = 7; i >= 0; i--) begin
      if (b_reg[i]) begin
        skip = imul_shamt_width'(i);
      end
    end
  end

  //--------------------------------------------------------------------
  // Shifters
  //--------------------------------------------------------------------

  // Skip the zero run
  assign b_skip = b_reg >> skip;
  assign a_skip = a_reg << skip;

  // Bit now at position zero decides the add
  assign b_lsb = b_skip[0];

  // One more position past the bit just handled
  assign b_next = b_skip >> 1;
  assign a_next = a_skip << 1;

  // Anything left to do
  assign b_more = |b_next;

  //--------------------------------------------------------------------
  // Adder and result register
  //--------------------------------------------------------------------

  assign sum = result_reg + a_skip;

  always_comb begin
    if (result_clear) begin
      result_next = '0;
    end else if (add_sel) begin
      result_next = sum;
    end else begin
      result_next = result_reg;
    end
  end

  // Holds while result_en is low, e.g. while waiting in done
  always_ff @(posedge clk) begin
    if (reset) begin
      result_reg <= '0;
    end else if (result_en) begin
      result_reg <= result_next;
    end
  end

  assign product.product = result_reg;

endmodule

`default_nettype wire

// File: logic/imul_ctrl.sv
/*
  Control FSM for the multiplier: idle loads, calc iterates until b is
  used up, done holds the product until the response queue takes it.
*/

`timescale 1ns/10ps
`default_nettype none

module imul_ctrl (
  input  wire  clk,
  input  wire  reset,

  // Request queue side
  input  wire  deq_val,
  output logic deq_rdy,

  // Response queue side
  output logic enq_val,
  input  wire  enq_rdy,

  // To datapath
  output logic a_sel,
  output logic b_sel,
  output logic add_sel,
  output logic result_clear,
  output logic result_en,

  // From datapath
  input  wire  b_more,
  input  wire  b_lsb
);

  import imul_pkg::*;

  // Control word, one row of the table below
  typedef struct packed {
    logic deq_rdy;
    logic enq_val;
    logic a_sel;
    logic b_sel;
    logic add_sel;
    logic result_clear;
    logic result_en;
  } ctrl_word_t;

  imul_state_e state;
  imul_state_e state_next;
  ctrl_word_t  cw;
  logic        deq_go;
  logic        enq_go;

  //--------------------------------------------------------------------
  // State register and transitions
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= state_idle;
    end else begin
      state <= state_next;
    end
  end

  assign deq_go = deq_val & deq_rdy;
  assign enq_go = enq_val & enq_rdy;

  always_comb begin
    state_next = state;
    case (state)
      state_idle: if (deq_go) state_next = state_calc;
      // Last step when nothing is left in b
      state_calc: if (!b_more) state_next = state_done;
      state_done: if (enq_go) state_next = state_idle;
      default:    state_next = state_idle;
    endcase
  end

  //--------------------------------------------------------------------
  // Output table
  //--------------------------------------------------------------------

  function automatic ctrl_word_t cs(input logic c_deq_rdy, input logic c_enq_val,
                                    input logic c_a_sel, input logic c_b_sel,
                                    input logic c_add_sel, input logic c_clear,
                                    input logic c_en);
    ctrl_word_t w;
    w.deq_rdy      = c_deq_rdy;
    w.enq_val      = c_enq_val;
    w.a_sel        = c_a_sel;
    w.b_sel        = c_b_sel;
    w.add_sel      = c_add_sel;
    w.result_clear = c_clear;
    w.result_en    = c_en;
    return w;
  endfunction

  always_comb begin
    //                  deq enq a    b    add    res  res
    //                  rdy val sel  sel  sel    clr  en
    cw = cs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0,  1'b0, 1'b0);
    case (state)
      state_idle: cw = cs(1'b1, 1'b0, 1'b1, 1'b1, 1'b0,  1'b1, 1'b1);
      state_calc: cw = cs(1'b0, 1'b0, 1'b0, 1'b0, b_lsb, 1'b0, 1'b1);
      state_done: cw = cs(1'b0, 1'b1, 1'b0, 1'b0, 1'b0,  1'b0, 1'b0);
      default:    cw = cs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0,  1'b0, 1'b0);
    endcase
  end

  assign deq_rdy      = cw.deq_rdy;
  assign enq_val      = cw.enq_val;
  assign a_sel        = cw.a_sel;
  assign b_sel        = cw.b_sel;
  assign add_sel      = cw.add_sel;
  assign result_clear = cw.result_clear;
  assign result_en    = cw.result_en;

endmodule

`default_nettype wire

// File: logic/imul_resp_queue.sv
/*
  One-entry response buffer. resp_msg holds steady while resp_val is high
  and resp_rdy is low.
*/

`timescale 1ns/10ps
`default_nettype none

module imul_resp_queue (
  input  wire                   clk,
  input  wire                   reset,

  // From the multiplier
  input  wire                   enq_val,
  output logic                  enq_rdy,
  input  imul_pkg::imul_resp_t  enq_msg,

  // To the consumer
  output logic                  resp_val,
  input  wire                   resp_rdy,
  output imul_pkg::imul_resp_t  resp_msg
);

  import imul_pkg::*;

  logic       full;
  logic       enq_go;
  logic       resp_go;
  imul_resp_t msg_reg;

  assign enq_go  = enq_val & enq_rdy;
  assign resp_go = resp_val & resp_rdy;

  // Room when empty or draining this cycle
  assign enq_rdy = ~full | resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (enq_go) begin
      full <= 1'b1;
    end else if (resp_go) begin
      full <= 1'b0;
    end
  end

  // Product storage
  always_ff @(posedge clk) begin
    if (enq_go) begin
      msg_reg <= enq_msg;
    end
  end

  assign resp_val = full;
  assign resp_msg = msg_reg;

endmodule

`default_nettype wire

// File: logic/imul_var_lat.sv
/*
  Variable-latency 32-bit multiplier, low half of the product only.
  Up to three operations in flight across the two queues and the FSM.
*/

`timescale 1ns/10ps
`default_nettype none

module imul_var_lat (
  input  wire                   clk,
  input  wire                   reset,

  // Request port
  input  wire                   req_val,
  output logic                  req_rdy,
  input  imul_pkg::imul_req_t   req_msg,

  // Response port
  output logic                  resp_val,
  input  wire                   resp_rdy,
  output imul_pkg::imul_resp_t  resp_msg
);

  import imul_pkg::*;

  // Request queue to control and datapath
  logic       deq_val;
  logic       deq_rdy;
  imul_req_t  deq_msg;

  // Control and datapath to response queue
  logic       enq_val;
  logic       enq_rdy;
  imul_resp_t product;

  // Control to datapath
  logic       a_sel;
  logic       b_sel;
  logic       add_sel;
  logic       result_clear;
  logic       result_en;

  // Datapath status
  logic       b_more;
  logic       b_lsb;

  //--------------------------------------------------------------------
  // Input side
  //--------------------------------------------------------------------

  imul_req_queue req_queue (
    .clk     (clk),
    .reset   (reset),
    .enq_val (req_val),
    .enq_rdy (req_rdy),
    .enq_msg (req_msg),
    .deq_val (deq_val),
    .deq_rdy (deq_rdy),
    .deq_msg (deq_msg)
  );

  //--------------------------------------------------------------------
  // Multiplier
  //--------------------------------------------------------------------

  imul_ctrl ctrl (
    .clk          (clk),
    .reset        (reset),
    .deq_val      (deq_val),
    .deq_rdy      (deq_rdy),
    .enq_val      (enq_val),
    .enq_rdy      (enq_rdy),
    .a_sel        (a_sel),
    .b_sel        (b_sel),
    .add_sel      (add_sel),
    .result_clear (result_clear),
    .result_en    (result_en),
    .b_more       (b_more),
    .b_lsb        (b_lsb)
  );

  imul_dpath dpath (
    .clk          (clk),
    .reset        (reset),
    .req          (deq_msg),
    .product      (product),
    .a_sel        (a_sel),
    .b_sel        (b_sel),
    .add_sel      (add_sel),
    .result_clear (result_clear),
    .result_en    (result_en),
    .b_more       (b_more),
    .b_lsb        (b_lsb)
  );

  //--------------------------------------------------------------------
  // Output side
  //--------------------------------------------------------------------

  imul_resp_queue resp_queue (
    .clk      (clk),
    .reset    (reset),
    .enq_val  (enq_val),
    .enq_rdy  (enq_rdy),
    .enq_msg  (product),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

endmodule

`default_nettype wire

// File: tests/imul_var_lat_tb.sv
/*
  Testbench for the variable-latency multiplier. Vectors come from
  tests/imul_golden.dat, so the simulation must start in the project root.
*/

`timescale 1ns/10ps
`default_nettype none

module imul_var_lat_tb;

  import imul_pkg::*;

  //--------------------------------------------------------------------
  // Test constants
  //--------------------------------------------------------------------

  // Must match the number of rows in the golden file
  localparam int num_vectors    = 29;
  localparam int golden_words   = 3 * num_vectors;
  localparam int word_idx_width = $clog2(golden_words);

  // Per-wait limits in cycles
  localparam int req_timeout  = 1000;
  localparam int resp_timeout = 1000;

  // One long stall of resp_rdy after this many responses
  localparam int stall_at  = 4;
  localparam int stall_len = 150;

  // Right-shifting Galois LFSR
  localparam logic [31:0] lfsr_seed = 32'h49bb;
  localparam logic [31:0] lfsr_mask = 32'hB4BC_D35C;

  logic       clk;
  logic       reset;
  logic       req_val;
  logic       req_rdy;
  imul_req_t  req_msg;
  logic       resp_val;
  logic       resp_rdy;
  imul_resp_t resp_msg;

  // Raw file words and the per-column queues
  logic [imul_width-1:0] golden_mem [0:golden_words-1];
  logic [imul_width-1:0] vec_a [$];
  logic [imul_width-1:0] vec_b [$];
  logic [imul_width-1:0] vec_p [$];

  int          error_count;
  int          check_count;
  int          sent_count;
  int          recv_count;
  logic        saw_req_full;
  logic [31:0] lfsr_state;

  //--------------------------------------------------------------------
  // DUT and clock
  //--------------------------------------------------------------------

  imul_var_lat imul_var_lat_inst (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_msg  (req_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  initial clk = 1'b0;

  // 8 ns period
  always #4 clk = ~clk;

  //--------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic report_problem(input string msg);
    $display("Error: %s", msg);
    error_count++;
  endtask

  // One LFSR step after bit 0 is taken
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return (state >> 1) ^ (state[0] ? lfsr_mask : 32'h0);
  endfunction

  task automatic load_golden();
    $readmemh("tests/imul_golden.dat", golden_mem);
    // Each row holds a, b and the product
    for (int i = 0; i < num_vectors; i++) begin
      vec_a.push_back(golden_mem[word_idx_width'(3 * i)]);
      vec_b.push_back(golden_mem[word_idx_width'(3 * i + 1)]);
      vec_p.push_back(golden_mem[word_idx_width'(3 * i + 2)]);
    end
  endtask

  //--------------------------------------------------------------------
  // Request driver
  //--------------------------------------------------------------------

  // Runs 1 ns after each edge where req_rdy is settled
  task automatic drive_requests();
    int wait_cycles;
    for (int i = 0; i < num_vectors; i++) begin
      req_val     = 1'b1;
      req_msg.a   = vec_a[i];
      req_msg.b   = vec_b[i];
      wait_cycles = 0;
      while (!req_rdy && wait_cycles < req_timeout) begin
        @(posedge clk);
        #1;
        wait_cycles++;
      end
      if (!req_rdy) begin
        report_problem($sformatf("timed out waiting for req_rdy before request %0d", i));
        break;
      end
      // Transfer on the coming edge
      @(posedge clk);
      #1;
      sent_count++;
    end
    req_val = 1'b0;
    req_msg = '0;
  endtask

  //--------------------------------------------------------------------
  // Response checker
  //--------------------------------------------------------------------

  task automatic check_responses();
    int                    idle_cycles;
    int                    stall_left;
    logic                  stall_started;
    logic                  held_valid;
    logic [imul_width-1:0] held_product;
    logic                  accept;
    idle_cycles   = 0;
    stall_left    = 0;
    stall_started = 1'b0;
    held_valid    = 1'b0;
    held_product  = '0;
    accept        = 1'b0;
    while (recv_count < num_vectors && idle_cycles < resp_timeout) begin
      // Long forced stall once
      if (!stall_started && recv_count == stall_at) begin
        stall_started = 1'b1;
        stall_left    = stall_len;
      end
      if (stall_left > 0) begin
        resp_rdy = 1'b0;
        stall_left--;
        // Queues must have backed up to the request port by the last stall cycle
        if (stall_left == 0 && !req_rdy) begin
          saw_req_full = 1'b1;
        end
      end else begin
        resp_rdy   = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
      end
      accept = resp_val & resp_rdy;
      if (resp_val) begin
        // Stalled message must stay put
        if (held_valid) begin
          check_value($sformatf("held product %0d", recv_count), held_product,
                      resp_msg.product);
        end
        if (accept) begin
          check_value($sformatf("product %0d", recv_count), vec_p[recv_count],
                      resp_msg.product);
          held_valid = 1'b0;
        end else if (!held_valid) begin
          held_valid   = 1'b1;
          held_product = resp_msg.product;
        end
      end
      @(posedge clk);
      #1;
      if (accept) begin
        recv_count++;
        idle_cycles = 0;
      end else begin
        idle_cycles++;
      end
    end
    resp_rdy = 1'b0;
    if (recv_count < num_vectors) begin
      report_problem($sformatf("timed out waiting for response %0d", recv_count));
    end
  endtask

  // Two queues plus the FSM hold at most three operations
  always @(negedge clk) begin
    if (!reset && (sent_count - recv_count > 3)) begin
      report_problem($sformatf("more than three requests in flight, sent %0d received %0d",
                               sent_count, recv_count));
    end
  end

  //--------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------

  initial begin
    reset        = 1'b1;
    req_val      = 1'b0;
    req_msg      = '0;
    resp_rdy     = 1'b0;
    error_count  = 0;
    check_count  = 0;
    sent_count   = 0;
    recv_count   = 0;
    saw_req_full = 1'b0;
    lfsr_state   = lfsr_seed;
    load_golden();

    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    // Both queues empty out of reset
    check_value("req_rdy after reset", 32'd1, 32'(req_rdy));
    check_value("resp_val after reset", 32'd0, 32'(resp_val));

    fork
      drive_requests();
      check_responses();
    join

    if (!saw_req_full) begin
      report_problem("req_rdy was still high at the end of the long resp_rdy stall");
    end
    check_value("requests sent", num_vectors, sent_count);
    check_value("responses received", num_vectors, recv_count);

    $display("Summary: %0d checks, %0d errors, %0d sent, %0d received",
             check_count, error_count, sent_count, recv_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: imul_var_lat.f
logic/imul_pkg.sv
logic/imul_req_queue.sv
logic/imul_dpath.sv
logic/imul_ctrl.sv
logic/imul_resp_queue.sv
logic/imul_var_lat.sv
tests/imul_var_lat_tb.sv

// File: run_imul.sh
#!/bin/sh
# Builds the multiplier testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/10ps -f imul_var_lat.f \
  --top-module imul_var_lat_tb -Mdir obj_dir -o imul_var_lat_sim \
  && ./obj_dir/imul_var_lat_sim > sim.log 2>&1 \
  || { echo "Build or simulation did not complete, see sim.log"; exit 1; }

grep -qx "Testbench passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// File: tests/imul_golden.dat
// Columns: a, b, expected low 32 bits of a*b, all hex
// One vector per line, sent in file order
00000000 00000000 00000000
00000000 12345678 00000000
12345678 00000000 00000000
00000001 00000001 00000001
00000001 DEADBEEF DEADBEEF
CAFEBABE 00000001 CAFEBABE
FFFFFFFF FFFFFFFF 00000001
FFFFFFFF 00000002 FFFFFFFE
00000003 80000000 80000000
12345679 80000000 80000000
00000005 00000100 00000500
00000007 00010000 00070000
ABCD1234 01000000 34000000
00000011 40000001 40000011
0000FFFF 0000FFFF FFFE0001
00010001 00010001 00020001
00001000 00100000 00000000
00000002 7FFFFFFF FFFFFFFE
FFFFFFFF 00000100 FFFFFF00
00000003 AAAAAAAA FFFFFFFE
00000005 33333333 FFFFFFFF
00000007 24924924 FFFFFFFC
0000ABCD 00001234 0C374FA4
87654321 00000010 76543210
13579BDF 00000300 06D39D00
00000009 00000009 00000051
10000000 00000010 00000000
0001E240 00000064 00BC6100
DEADBEEF 00000003 9C093CCD
